/* Bender.yml */
package:
  name: tmr_timer

export_include_dirs:
  - logic

sources:
  - files:
      - logic/tmr_pkg.sv
      - logic/apb_reg_if.sv
      - logic/tmr_regs.sv
      - logic/event_counter.sv
      - logic/irq_combine.sv
      - logic/tmr_top.sv
  - target: simulation
    files:
      - dv/tmr_checker.sv
      - dv/tb_tmr.sv

/* dv/tb_tmr.sv */
`default_nettype none

`include "tmr_defs.svh"

module tb_tmr import tmr_pkg::*; ();

    localparam int NUM_RAND   = 400;
    localparam int NUM_FIXED  = 32;
    localparam int MAX_GAP    = 3;
    localparam int TX_CYCLES  = 4;
    localparam int ACK_LIMIT  = 8;
    localparam int CLK_PERIOD = 8;
    // every transfer at its longest, doubled, plus reset and drain.
    localparam longint WATCHDOG_TIME =
        2 * (NUM_RAND + NUM_FIXED) * (TX_CYCLES + MAX_GAP) * CLK_PERIOD + 100 * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        resetn;
    logic        psel;
    logic        pwrite;
    logic        penable;
    addr_t       paddr;
    data_t       pwdata;
    data_t       prdata;
    logic        pready;
    logic        ev_a;
    logic        ev_b;
    logic        irq;
    logic [31:0] lfsr;
    int          bus_errors = 0;
    int          chk_errors;
    int          chk_checks;

    always #(CLK_PERIOD / 2) clk = ~clk;

    tmr_top UUT (
        .clk     (clk),
        .resetn  (resetn),
        .psel    (psel),
        .pwrite  (pwrite),
        .penable (penable),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .ev_a    (ev_a),
        .ev_b    (ev_b),
        .irq     (irq)
    );

    tmr_checker u_checker (
        .clk         (clk),
        .resetn      (resetn),
        .psel        (psel),
        .pwrite      (pwrite),
        .penable     (penable),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .ev_a        (ev_a),
        .ev_b        (ev_b),
        .irq         (irq),
        .err_count   (chk_errors),
        .check_count (chk_checks)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    // write data shaped per register so that matches happen.
    function automatic data_t rand_data(input reg_idx_t idx);
        data_t      d;
        logic [1:0] en;
        logic [1:0] clr;
        d = '0;
        case (idx)
            REG_CTRL: begin
                en  = (rand_bits(2) == 0) ? 2'(rand_bits(2)) : 2'b11; // mostly enabled.
                clr = (rand_bits(3) == 0) ? 2'(rand_bits(2)) : 2'b00;
                d[`TMR_CTRL_EN_A]  = en[0];
                d[`TMR_CTRL_EN_B]  = en[1];
                d[`TMR_CTRL_CLR_A] = clr[0];
                d[`TMR_CTRL_CLR_B] = clr[1];
            end
            REG_CMP_A, REG_CMP_B: d = data_t'(rand_bits(4));
            REG_STATUS, REG_MASK: d = data_t'(rand_bits(2));
            default:              d = rand_bits(32);
        endcase
        return d;
    endfunction

    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        r = rand_bits(2);
        ev_a <= r[0];
        ev_b <= r[1];
    endtask

    task automatic apb_xfer(input logic wr, input reg_idx_t idx, input data_t data);
        int waited;
        tick();
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr_t'(idx) << `TMR_BYTE_BITS;
        pwdata  <= data;
        tick();
        penable <= 1'b1;
        waited = 0;
        do begin
            tick();
            waited++;
        end while (!pready && waited < ACK_LIMIT);
        if (!pready) begin
            $display("pready never came for register %0d at time %0t", idx, $time);
            bus_errors++;
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input reg_idx_t idx, input data_t data);
        apb_xfer(1'b1, idx, data);
    endtask

    task automatic apb_read(input reg_idx_t idx);
        apb_xfer(1'b0, idx, '0);
    endtask

    initial begin
        reg_idx_t idx;
        lfsr    = 32'h872a_27db;
        resetn  = 1'b0;
        psel    = 1'b0;
        pwrite  = 1'b0;
        penable = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        ev_a    = 1'b0;
        ev_b    = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < `TMR_REG_NUM; i++) begin
            apb_read(reg_idx_t'(i)); // reset values.
        end
        apb_write(REG_CMP_A, 32'd5);
        apb_write(REG_CMP_B, 32'd3);
        apb_write(REG_MASK, 32'h1); // b matches stay masked off.
        apb_write(REG_CTRL, 32'hf);
        apb_write(REG_CNT_A, 32'hffff_ffff); // counters running, no clear after.
        apb_write(REG_CNT_B, 32'hffff_ffff);
        apb_write(REG_ID, 32'h0);
        for (int i = 0; i < `TMR_REG_NUM; i++) begin
            apb_read(reg_idx_t'(i));
        end
        apb_write(REG_CTRL, 32'h7); // clear a only.
        apb_read(REG_CNT_A);
        apb_read(REG_CNT_B);
        apb_write(REG_STATUS, 32'h3);
        apb_read(REG_STATUS);

        for (int n = 0; n < NUM_RAND; n++) begin
            idx = reg_idx_t'(rand_bits(3));
            if (rand_bits(1)) begin
                apb_write(idx, rand_data(idx));
            end else begin
                apb_read(idx);
            end
            repeat (rand_bits(2)) begin
                tick();
            end
        end
        repeat (4) begin
            tick();
        end

        $display("checks: %0d, checker errors: %0d, bus errors: %0d",
                 chk_checks, chk_errors, bus_errors);
        if (chk_errors == 0 && bus_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tmr_checker.sv */
`default_nettype none

`include "tmr_defs.svh"

module tmr_checker import tmr_pkg::*; (
    input  wire logic  clk,
    input  wire logic  resetn,
    input  wire logic  psel,
    input  wire logic  pwrite,
    input  wire logic  penable,
    input  wire addr_t paddr,
    input  wire data_t pwdata,
    input  wire data_t prdata,
    input  wire logic  pready,
    input  wire logic  ev_a,
    input  wire logic  ev_b,
    input  wire logic  irq,
    output int         err_count,
    output int         check_count
);

    // model state, each one the value held before the edge.
    logic       acc;
    logic       wr_pend;
    logic       rd_pend;
    reg_idx_t   wr_idx;
    data_t      wr_data;
    data_t      exp_rd;
    logic       en_a;
    logic       en_b;
    data_t      cmp_a;
    data_t      cmp_b;
    data_t      cnt_a;
    data_t      cnt_b;
    logic       match_a;
    logic       match_b;
    logic [1:0] mask;
    logic [1:0] status;

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    function automatic data_t reg_value(input reg_idx_t idx);
        data_t v;
        v = '0;
        case (idx)
            REG_CTRL: begin
                v[`TMR_CTRL_EN_A] = en_a;
                v[`TMR_CTRL_EN_B] = en_b;
            end
            REG_CMP_A:  v = cmp_a;
            REG_CMP_B:  v = cmp_b;
            REG_CNT_A:  v = cnt_a;
            REG_CNT_B:  v = cnt_b;
            REG_STATUS: v[1:0] = status;
            REG_MASK:   v[1:0] = mask;
            REG_ID:     v = `TMR_ID_VALUE;
            default:    v = '0;
        endcase
        return v;
    endfunction

    // next {match, count} of one counter.
    function automatic logic [`TMR_DATA_W:0] count_step(
        input logic  en,
        input logic  clr,
        input logic  ev,
        input data_t cmp,
        input data_t cnt
    );
        if (clr) begin
            return '0;
        end
        if (en && ev) begin
            if (cmp != '0 && cnt == cmp - 1) begin
                return {1'b1, {`TMR_DATA_W{1'b0}}}; // wrap with match.
            end
            return {1'b0, data_t'(cnt + 1'b1)};
        end
        return {1'b0, cnt};
    endfunction

    always @(posedge clk) begin
        logic                 setup;
        logic                 clr_a;
        logic                 clr_b;
        logic [1:0]           sclr;
        logic [`TMR_DATA_W:0] nxt_a;
        logic [`TMR_DATA_W:0] nxt_b;
        reg_idx_t             idx;
        if (!resetn) begin
            acc     <= 1'b0;
            wr_pend <= 1'b0;
            rd_pend <= 1'b0;
            en_a    <= 1'b0;
            en_b    <= 1'b0;
            cmp_a   <= '0;
            cmp_b   <= '0;
            cnt_a   <= '0;
            cnt_b   <= '0;
            match_a <= 1'b0;
            match_b <= 1'b0;
            mask    <= 2'b00;
            status  <= 2'b00;
        end else begin
            check_count = check_count + 2;
            if (irq !== |(status & mask)) begin
                $display("[FAIL] %0t: irq is %b, model expects %b", $time, irq, |(status & mask));
                err_count = err_count + 1;
            end
            if (pready !== acc) begin
                $display("[FAIL] %0t: pready is %b, model expects %b", $time, pready, acc);
                err_count = err_count + 1;
            end
            if (acc && rd_pend) begin
                check_count = check_count + 1;
                if (prdata !== exp_rd) begin
                    $display("[FAIL] %0t: prdata %h, model expects %h", $time, prdata, exp_rd);
                    err_count = err_count + 1;
                end
            end

            setup = !acc && psel && !penable;
            idx   = reg_idx_t'(paddr[`TMR_BYTE_BITS +: IDX_W]);
            clr_a = wr_pend && (wr_idx == REG_CTRL) && wr_data[`TMR_CTRL_CLR_A];
            clr_b = wr_pend && (wr_idx == REG_CTRL) && wr_data[`TMR_CTRL_CLR_B];
            sclr  = (wr_pend && wr_idx == REG_STATUS) ? wr_data[1:0] : 2'b00;
            nxt_a = count_step(en_a, clr_a, ev_a, cmp_a, cnt_a);
            nxt_b = count_step(en_b, clr_b, ev_b, cmp_b, cnt_b);

            acc     <= setup;
            wr_pend <= setup && pwrite;
            rd_pend <= setup && !pwrite;
            if (setup) begin
                wr_idx  <= idx;
                wr_data <= pwdata;
                exp_rd  <= reg_value(idx); // contents at the setup edge.
            end
            if (wr_pend) begin
                case (wr_idx)
                    REG_CTRL: begin
                        en_a <= wr_data[`TMR_CTRL_EN_A];
                        en_b <= wr_data[`TMR_CTRL_EN_B];
                    end
                    REG_CMP_A: cmp_a <= wr_data;
                    REG_CMP_B: cmp_b <= wr_data;
                    REG_MASK:  mask <= wr_data[1:0];
                    default: begin
                    end
                endcase
            end
            {match_a, cnt_a} <= nxt_a;
            {match_b, cnt_b} <= nxt_b;
            status <= {match_b, match_a} | (status & ~sclr); // a new match wins.
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+logic
logic/tmr_pkg.sv
logic/apb_reg_if.sv
logic/tmr_regs.sv
logic/event_counter.sv
logic/irq_combine.sv
logic/tmr_top.sv
dv/tmr_checker.sv
dv/tb_tmr.sv

/* logic/apb_reg_if.sv */
`default_nettype none

`include "tmr_defs.svh"

module apb_reg_if import tmr_pkg::*; (
    input  wire logic     clk,
    input  wire logic     resetn,

    input  wire logic     psel,
    input  wire logic     pwrite,
    input  wire logic     penable,
    input  wire addr_t    paddr,
    input  wire data_t    pwdata,
    output data_t         prdata,
    output logic          pready,

    output logic          wr_en,
    output reg_idx_t      wr_idx,
    output data_t         wr_data,
    output reg_idx_t      rd_idx,
    input  wire data_t    rd_data
);

    typedef enum logic {
        ST_IDLE,
        ST_ACCESS
    } state_t;

    state_t   state;
    logic     setup;
    reg_idx_t addr_idx;

    // setup phase only counts while idle.
    assign setup = (state == ST_IDLE) && psel && !penable;

    // word index sits right above the byte offset.
    assign addr_idx = reg_idx_t'(paddr[`TMR_BYTE_BITS +: IDX_W]);
    assign rd_idx   = addr_idx;

    assign pready = (state == ST_ACCESS); // one cycle per transfer.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
            wr_en <= 1'b0;
        end else begin
            wr_en <= setup && pwrite;
            case (state)
                ST_IDLE: begin
                    if (setup) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    state <= ST_IDLE; // transfer ends here.
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // payload capture on the setup edge.
    always_ff @(posedge clk) begin
        if (setup) begin
            if (pwrite) begin
                wr_idx  <= addr_idx;
                wr_data <= pwdata;
            end else begin
                prdata <= rd_data; // contents as of this edge.
            end
        end
    end

    // the access state never repeats, so no back-to-back acks.
    a_pready_single: assert property (
        @(posedge clk) disable iff (!resetn)
        pready |=> !pready
    );

    // a write strobe always follows a write setup phase.
    a_wr_after_setup: assert property (
        @(posedge clk) disable iff (!resetn)
        wr_en |-> $past(psel && !penable && pwrite)
    );

endmodule

`default_nettype wire

/* logic/event_counter.sv */
`default_nettype none

module event_counter import tmr_pkg::*; (
    input  wire logic  clk,
    input  wire logic  resetn,
    input  wire logic  enable,
    input  wire logic  clear,
    input  wire logic  ev,
    input  wire data_t cmp,
    output data_t      count,
    output logic       match
);

    logic at_cmp;

    // zero compare means free running.
    assign at_cmp = (cmp != '0) && (count == data_t'(cmp - 1'b1));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
            match <= 1'b0;
        end else if (clear) begin
            count <= '0; // no match on clear.
            match <= 1'b0;
        end else if (enable && ev) begin
            if (at_cmp) begin
                count <= '0;
                match <= 1'b1;
            end else begin
                count <= count + 1'b1;
                match <= 1'b0;
            end
        end else begin
            match <= 1'b0;
        end
    end

    // holds as long as software leaves cmp alone.
    a_count_below_cmp: assert property (
        @(posedge clk) disable iff (!resetn)
        (cmp != '0 && count < cmp) ##1 $stable(cmp) |-> count < cmp
    );

endmodule

`default_nettype wire

/* logic/irq_combine.sv */
`default_nettype none

module irq_combine (
    input  wire logic       clk,
    input  wire logic       resetn,
    input  wire logic       match_a,
    input  wire logic       match_b,
    input  wire logic [1:0] status_clr,
    input  wire logic [1:0] mask,
    output logic [1:0]      status,
    output logic            irq
);

    logic [1:0] match;

    assign match = {match_b, match_a};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            status <= 2'b00;
        end else begin
            status <= match | (status & ~status_clr); // set beats clear.
        end
    end

    assign irq = |(status & mask);

    // a new interrupt needs a fresh match or a mask change.
    a_irq_cause: assert property (
        @(posedge clk) disable iff (!resetn)
        $rose(irq) |-> $changed(mask) || $past(match_a || match_b)
    );

endmodule

`default_nettype wire

/* logic/tmr_defs.svh */
`ifndef TMR_DEFS_SVH
`define TMR_DEFS_SVH

// bus and register file geometry
`define TMR_DATA_W      32
`define TMR_REG_NUM     8
`define TMR_ADDR_W      32
`define TMR_BYTE_BITS   2

// control register bit positions
`define TMR_CTRL_EN_A   0
`define TMR_CTRL_EN_B   1
`define TMR_CTRL_CLR_A  2
`define TMR_CTRL_CLR_B  3

`define TMR_ID_VALUE    32'h544d_5201

`endif

/* logic/tmr_pkg.sv */
`default_nettype none

`include "tmr_defs.svh"

package tmr_pkg;

    localparam int IDX_W = $clog2(`TMR_REG_NUM);

    typedef logic [`TMR_DATA_W-1:0] data_t;
    typedef logic [`TMR_ADDR_W-1:0] addr_t;

    // word index of each register, byte address is index * 4.
    typedef enum logic [IDX_W-1:0] {
        REG_CTRL   = 'd0,
        REG_CMP_A  = 'd1,
        REG_CMP_B  = 'd2,
        REG_CNT_A  = 'd3,
        REG_CNT_B  = 'd4,
        REG_STATUS = 'd5,
        REG_MASK   = 'd6,
        REG_ID     = 'd7
    } reg_idx_t;

endpackage

`default_nettype wire

/* logic/tmr_regs.sv */
`default_nettype none

`include "tmr_defs.svh"

module tmr_regs import tmr_pkg::*; (
    input  wire logic      clk,
    input  wire logic      resetn,

    input  wire logic      wr_en,
    input  wire reg_idx_t  wr_idx,
    input  wire data_t     wr_data,
    input  wire reg_idx_t  rd_idx,
    output data_t          rd_data,

    input  wire data_t     count_a,
    input  wire data_t     count_b,
    input  wire logic [1:0] status,

    output logic           en_a,
    output logic           en_b,
    output logic           clr_a,
    output logic           clr_b,
    output data_t          cmp_a,
    output data_t          cmp_b,
    output logic [1:0]     mask,
    output logic [1:0]     status_clr
);

    logic ctrl_wr;
    logic status_wr;

    assign ctrl_wr   = wr_en && (wr_idx == REG_CTRL);
    assign status_wr = wr_en && (wr_idx == REG_STATUS);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            en_a  <= 1'b0;
            en_b  <= 1'b0;
            cmp_a <= '0;
            cmp_b <= '0;
            mask  <= 2'b00;
        end else if (wr_en) begin
            case (wr_idx)
                REG_CTRL: begin
                    en_a <= wr_data[`TMR_CTRL_EN_A];
                    en_b <= wr_data[`TMR_CTRL_EN_B];
                end
                REG_CMP_A: begin
                    cmp_a <= wr_data;
                end
                REG_CMP_B: begin
                    cmp_b <= wr_data;
                end
                REG_MASK: begin
                    mask <= wr_data[1:0];
                end
                default: begin
                    // counts, status and id hold no writable state here.
                end
            endcase
        end
    end

    // pulses ride on the single-cycle write strobe.
    assign clr_a      = ctrl_wr && wr_data[`TMR_CTRL_CLR_A];
    assign clr_b      = ctrl_wr && wr_data[`TMR_CTRL_CLR_B];
    assign status_clr = status_wr ? wr_data[1:0] : 2'b00; // w1c.

    always_comb begin
        rd_data = '0;
        case (rd_idx)
            REG_CTRL: begin
                rd_data[`TMR_CTRL_EN_A] = en_a; // clr bits read zero.
                rd_data[`TMR_CTRL_EN_B] = en_b;
            end
            REG_CMP_A: begin
                rd_data = cmp_a;
            end
            REG_CMP_B: begin
                rd_data = cmp_b;
            end
            REG_CNT_A: begin
                rd_data = count_a;
            end
            REG_CNT_B: begin
                rd_data = count_b;
            end
            REG_STATUS: begin
                rd_data[1:0] = status;
            end
            REG_MASK: begin
                rd_data[1:0] = mask;
            end
            REG_ID: begin
                rd_data = `TMR_ID_VALUE;
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

    a_clr_a_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        clr_a |=> !clr_a
    );

    a_clr_b_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        clr_b |=> !clr_b
    );

endmodule

`default_nettype wire

/* logic/tmr_top.sv */
`default_nettype none

module tmr_top import tmr_pkg::*; (
    input  wire logic  clk,
    input  wire logic  resetn,

    input  wire logic  psel,
    input  wire logic  pwrite,
    input  wire logic  penable,
    input  wire addr_t paddr,
    input  wire data_t pwdata,
    output data_t      prdata,
    output logic       pready,

    input  wire logic  ev_a,
    input  wire logic  ev_b,
    output logic       irq
);

    logic       wr_en;
    reg_idx_t   wr_idx;
    data_t      wr_data;
    reg_idx_t   rd_idx;
    data_t      rd_data;

    logic       en_a;
    logic       en_b;
    logic       clr_a;
    logic       clr_b;
    data_t      cmp_a;
    data_t      cmp_b;
    data_t      count_a;
    data_t      count_b;
    logic       match_a;
    logic       match_b;

    logic [1:0] mask;
    logic [1:0] status;
    logic [1:0] status_clr;

    apb_reg_if u_apb (
        .clk     (clk),
        .resetn  (resetn),
        .psel    (psel),
        .pwrite  (pwrite),
        .penable (penable),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .rd_idx  (rd_idx),
        .rd_data (rd_data)
    );

    tmr_regs u_regs (
        .clk        (clk),
        .resetn     (resetn),
        .wr_en      (wr_en),
        .wr_idx     (wr_idx),
        .wr_data    (wr_data),
        .rd_idx     (rd_idx),
        .rd_data    (rd_data),
        .count_a    (count_a),
        .count_b    (count_b),
        .status     (status),
        .en_a       (en_a),
        .en_b       (en_b),
        .clr_a      (clr_a),
        .clr_b      (clr_b),
        .cmp_a      (cmp_a),
        .cmp_b      (cmp_b),
        .mask       (mask),
        .status_clr (status_clr)
    );

    event_counter u_cnt_a (
        .clk    (clk),
        .resetn (resetn),
        .enable (en_a),
        .clear  (clr_a),
        .ev     (ev_a),
        .cmp    (cmp_a),
        .count  (count_a),
        .match  (match_a)
    );

    event_counter u_cnt_b (
        .clk    (clk),
        .resetn (resetn),
        .enable (en_b),
        .clear  (clr_b),
        .ev     (ev_b),
        .cmp    (cmp_b),
        .count  (count_b),
        .match  (match_b)
    );

    irq_combine u_irq (
        .clk        (clk),
        .resetn     (resetn),
        .match_a    (match_a),
        .match_b    (match_b),
        .status_clr (status_clr),
        .mask       (mask),
        .status     (status),
        .irq        (irq)
    );

endmodule

`default_nettype wire
